//--- hw/mmc_bit_adv.sv
module mmc_bit_adv import mmc_pkg::*; (
  input  logic         clk,
  input  logic         arst_n_i,
  input  mmc_req_t     req_i,
  input  logic         start_i,
  input  logic         smp_pulse_i,
  input  logic         drv_pulse_i,
  input  mmc_pins_in_t pins_i,
  output logic         cmd_o,
  output logic         cmd_oe_o,
  output mmc_byte_t    dat_o,
  output logic         dat_oe_o,
  output mmc_byte_t    rd_byte_o,
  output logic         done_o
);

  bit_idx_t  wr_idx;
  bit_idx_t  rd_idx;
  bit_idx_t  last_idx;
  mmc_byte_t acc;
  mmc_byte_t acc_nxt;
  logic      active;
  logic      on_cmd;
  logic      wr_bit;
  logic      drive_en;

  assign on_cmd = (req_i.mode == CMD_RD) || (req_i.mode == CMD_WR);

  // Last slot index: CMD and DW_1 take 8 slots, DW_4 two, DW_8 one.
  always_comb begin
    last_idx = 3'd7;
    if (!on_cmd) begin
      case (req_i.width)
        DW_4:    last_idx = 3'd1;
        DW_8:    last_idx = 3'd0;
        default: last_idx = 3'd7;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_idx <= '0;
    end else if (done_o) begin
      wr_idx <= '0;                             // Ready for the next start.
    end else if (active && drv_pulse_i) begin
      wr_idx <= wr_idx + 3'd1;
    end
  end

  assign wr_bit = req_i.wr_byte[3'd7 - wr_idx]; // MSB first.
  assign cmd_o  = wr_bit;

  always_comb begin
    case (req_i.width)
      DW_1:    dat_o = {7'b0, wr_bit};
      DW_4:    dat_o = {4'b0, wr_idx[0] ? req_i.wr_byte[3:0] : req_i.wr_byte[7:4]};
      default: dat_o = req_i.wr_byte;
    endcase
  end

  // Shift in the current slot; the last slot is merged live from the pins.
  always_comb begin
    if (on_cmd) begin
      acc_nxt = {acc[6:0], pins_i.cmd};
    end else begin
      case (req_i.width)
        DW_1:    acc_nxt = {acc[6:0], pins_i.dat[0]};
        DW_4:    acc_nxt = {acc[3:0], pins_i.dat[3:0]};
        default: acc_nxt = pins_i.dat;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (active && smp_pulse_i) begin
      acc <= acc_nxt;
    end
  end

  assign rd_byte_o = acc_nxt;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active <= 1'b0;
      rd_idx <= '0;
    end else if (start_i) begin
      active <= 1'b1;
      rd_idx <= '0;
    end else if (done_o) begin
      active <= 1'b0;
    end else if (active && smp_pulse_i) begin
      rd_idx <= rd_idx + 3'd1;
    end
  end

  assign done_o = active && smp_pulse_i && (rd_idx == last_idx);

  assign drive_en = start_i || active;
  assign cmd_oe_o = drive_en && (req_i.mode == CMD_WR);
  assign dat_oe_o = drive_en && (req_i.mode == DAT_WR);

  // The divider never gives a rising edge right after the start strobe.
  a_done_on_sample: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    done_o |-> smp_pulse_i && !$past(start_i)
  );

endmodule

//--- hw/mmc_clk_div.sv
`include "mmc_params.svh"

module mmc_clk_div (
  input  logic clk,
  input  logic arst_n_i,
  input  logic run_i,
  output logic card_clk_o,
  output logic smp_pulse_o,
  output logic drv_pulse_o
);

  localparam logic [7:0] div_last = 8'(`MMC_CLK_DIV - 1);

  logic [7:0] cnt;
  logic       toggle;

  assign toggle = run_i && (cnt == div_last);   // End of a half period.

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt <= '0;
    end else if (!run_i || toggle) begin
      cnt <= '0;                                // Idle restarts the half period.
    end else begin
      cnt <= cnt + 8'd1;
    end
  end

  // Pulses are registered with the clock so they line up with its edges.
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      card_clk_o  <= 1'b0;
      smp_pulse_o <= 1'b0;
      drv_pulse_o <= 1'b0;
    end else if (!run_i) begin
      card_clk_o  <= 1'b0;
      smp_pulse_o <= 1'b0;
      drv_pulse_o <= 1'b0;
    end else begin
      smp_pulse_o <= toggle && !card_clk_o;     // Rising card edge.
      drv_pulse_o <= toggle && card_clk_o;      // Falling card edge.
      if (toggle) begin
        card_clk_o <= !card_clk_o;
      end
    end
  end

  a_pulses_exclusive: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    !(smp_pulse_o && drv_pulse_o)
  );

endmodule

//--- hw/mmc_host.sv
module mmc_host import mmc_pkg::*; (
  input  logic          clk,
  input  logic          arst_n_i,
  input  logic          req_valid_i,
  input  mmc_req_t      req_i,
  output logic          busy_o,
  output logic          done_o,
  output logic          rd_valid_o,
  output mmc_byte_t     rd_byte_o,
  output mmc_pins_out_t pins_o,
  input  mmc_pins_in_t  pins_i
);

  mmc_req_t  cur_req;
  logic      adv_start;
  logic      run;
  logic      card_clk;
  logic      smp_pulse;
  logic      drv_pulse;
  logic      adv_done;
  mmc_byte_t adv_rd_byte;
  logic      cmd;
  logic      cmd_oe;
  mmc_byte_t dat;
  logic      dat_oe;
  mmc_byte_t lane_mask;

  mmc_req_decode i_mmc_req_decode (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .adv_done_i  (adv_done),
    .cur_req_o   (cur_req),
    .adv_start_o (adv_start),
    .run_o       (run),
    .busy_o      (busy_o)
  );

  mmc_clk_div i_mmc_clk_div (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .run_i       (run),
    .card_clk_o  (card_clk),
    .smp_pulse_o (smp_pulse),
    .drv_pulse_o (drv_pulse)
  );

  mmc_bit_adv i_mmc_bit_adv (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_i       (cur_req),
    .start_i     (adv_start),
    .smp_pulse_i (smp_pulse),
    .drv_pulse_i (drv_pulse),
    .pins_i      (pins_i),
    .cmd_o       (cmd),
    .cmd_oe_o    (cmd_oe),
    .dat_o       (dat),
    .dat_oe_o    (dat_oe),
    .rd_byte_o   (adv_rd_byte),
    .done_o      (adv_done)
  );

  mmc_rx_result i_mmc_rx_result (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .adv_done_i (adv_done),
    .mode_i     (cur_req.mode),
    .rd_byte_i  (adv_rd_byte),
    .rd_byte_o  (rd_byte_o),
    .rd_valid_o (rd_valid_o),
    .done_o     (done_o)
  );

  // Only the lanes of the selected width are driven.
  always_comb begin
    case (cur_req.width)
      DW_1:    lane_mask = 8'h01;
      DW_4:    lane_mask = 8'h0f;
      default: lane_mask = 8'hff;
    endcase
  end

  assign pins_o = '{
    card_clk: card_clk,
    cmd:      cmd,
    cmd_oe:   cmd_oe,
    dat:      dat,
    dat_oe:   dat_oe ? lane_mask : 8'h00
  };

endmodule

//--- hw/mmc_pkg.sv
package mmc_pkg;

  typedef logic [7:0] mmc_byte_t;
  typedef logic [2:0] bit_idx_t;                 // Slot index within one byte.

  typedef enum logic [1:0] {
    CMD_RD = 2'd0,
    CMD_WR = 2'd1,
    DAT_RD = 2'd2,
    DAT_WR = 2'd3
  } adv_mode_e;

  typedef enum logic [1:0] {
    DW_1 = 2'd0,
    DW_4 = 2'd1,
    DW_8 = 2'd2                                  // 2'd3 is not a legal width.
  } bus_width_e;

  typedef struct packed {
    adv_mode_e  mode;
    bus_width_e width;
    mmc_byte_t  wr_byte;
  } mmc_req_t;

  typedef struct packed {
    logic      card_clk;
    logic      cmd;
    logic      cmd_oe;
    mmc_byte_t dat;
    mmc_byte_t dat_oe;                           // One enable per DAT lane.
  } mmc_pins_out_t;

  typedef struct packed {
    logic      cmd;
    mmc_byte_t dat;
  } mmc_pins_in_t;

  typedef enum logic [1:0] {
    IDLE,
    START,
    RUN
  } dec_state_e;

endpackage

//--- hw/mmc_req_decode.sv
`include "mmc_params.svh"

module mmc_req_decode import mmc_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     req_valid_i,
  input  mmc_req_t req_i,
  input  logic     adv_done_i,
  output mmc_req_t cur_req_o,
  output logic     adv_start_o,
  output logic     run_o,
  output logic     busy_o
);

  dec_state_e state;
  dec_state_e state_nxt;
  logic       accept;

  assign accept = (state == IDLE) && req_valid_i;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (req_valid_i) begin
          state_nxt = START;
        end
      end
      START: begin
        state_nxt = RUN;                        // Start strobe lasts one cycle.
      end
      RUN: begin
        if (adv_done_i) begin
          state_nxt = IDLE;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Request stays fixed for the whole transfer.
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_req_o <= req_i;
    end
  end

  assign adv_start_o = (state == START);
  assign run_o       = (state != IDLE);        // Card clock runs from START on.
  assign busy_o      = (state != IDLE);

  a_no_req_while_busy: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    req_valid_i |-> !busy_o
  );

  a_legal_width: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    req_valid_i |-> req_i.width inside {DW_1, DW_4, DW_8}
  );

  // The bit-advance block and the divider must finish every transfer.
  a_transfer_ends: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    adv_start_o |-> ##[1:`MMC_TIMEOUT] adv_done_i
  );

  a_done_only_in_run: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    adv_done_i |-> state == RUN
  );

endmodule

//--- hw/mmc_rx_result.sv
module mmc_rx_result import mmc_pkg::*; (
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      adv_done_i,
  input  adv_mode_e mode_i,
  input  mmc_byte_t rd_byte_i,
  output mmc_byte_t rd_byte_o,
  output logic      rd_valid_o,
  output logic      done_o
);

  logic is_rd;
  logic rd_take;

  assign is_rd   = (mode_i == CMD_RD) || (mode_i == DAT_RD);
  assign rd_take = adv_done_i && is_rd;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_o     <= 1'b0;
      rd_valid_o <= 1'b0;
    end else begin
      done_o     <= adv_done_i;
      rd_valid_o <= rd_take;                   // Writes complete without valid.
    end
  end

  // Held until the next read completes.
  always_ff @(posedge clk) begin
    if (rd_take) begin
      rd_byte_o <= rd_byte_i;
    end
  end

endmodule

//--- include/mmc_params.svh
`ifndef MMC_PARAMS_SVH
`define MMC_PARAMS_SVH

// Card clock half period, counted in clk cycles.
`define MMC_CLK_DIV 2

// Upper bound for any wait on a transfer, in clk cycles.
`define MMC_TIMEOUT 200

`endif

//--- mmc_host.f
+incdir+include
hw/mmc_pkg.sv
hw/mmc_clk_div.sv
hw/mmc_req_decode.sv
hw/mmc_bit_adv.sv
hw/mmc_rx_result.sv
hw/mmc_host.sv
verif/mmc_card_model.sv
verif/mmc_host_tb.sv

//--- verif/mmc_card_model.sv
module mmc_card_model import mmc_pkg::*; (
  input  logic          clr_i,
  input  adv_mode_e     mode_i,
  input  bus_width_e    width_i,
  input  mmc_byte_t     tx_byte_i,
  input  mmc_pins_out_t pins_i,
  output mmc_pins_in_t  pins_o,
  output mmc_byte_t     cap_byte_o,
  output logic [3:0]    cap_bits_o,
  output logic [3:0]    rise_cnt_o
);

  logic      card_clk;
  logic      on_cmd;
  bit_idx_t  slot;
  mmc_byte_t lanes;

  assign card_clk = pins_i.card_clk;
  assign on_cmd   = (mode_i == CMD_RD) || (mode_i == CMD_WR);
  assign lanes    = pins_i.dat & pins_i.dat_oe;    // Undriven lanes read as zero.

  // The card moves to its next slot on each falling card clock edge.
  always @(negedge card_clk or posedge clr_i) begin
    if (clr_i) begin
      slot <= '0;
    end else begin
      slot <= slot + 3'd1;
    end
  end

  always_comb begin
    pins_o.cmd = tx_byte_i[3'd7 - slot];           // MSB first.
    if (on_cmd) begin
      pins_o.dat = '0;
    end else begin
      case (width_i)
        DW_4:    pins_o.dat = {4'b0, slot[0] ? tx_byte_i[3:0] : tx_byte_i[7:4]};
        DW_8:    pins_o.dat = tx_byte_i;
        default: pins_o.dat = {7'b0, tx_byte_i[3'd7 - slot]};
      endcase
    end
  end

  // Host data is taken on rising card clock edges.
  always @(posedge card_clk or posedge clr_i) begin
    if (clr_i) begin
      cap_byte_o <= '0;
      cap_bits_o <= '0;
      rise_cnt_o <= '0;
    end else begin
      rise_cnt_o <= rise_cnt_o + 4'd1;
      if (pins_i.cmd_oe) begin
        cap_byte_o <= {cap_byte_o[6:0], pins_i.cmd};
        cap_bits_o <= cap_bits_o + 4'd1;
      end else if (pins_i.dat_oe != '0) begin
        case (width_i)
          DW_4: begin
            cap_byte_o <= {cap_byte_o[3:0], lanes[3:0]};
            cap_bits_o <= cap_bits_o + 4'd4;
          end
          DW_8: begin
            cap_byte_o <= lanes;
            cap_bits_o <= cap_bits_o + 4'd8;
          end
          default: begin
            cap_byte_o <= {cap_byte_o[6:0], lanes[0]};
            cap_bits_o <= cap_bits_o + 4'd1;
          end
        endcase
      end
    end
  end

endmodule

//--- verif/mmc_host_tb.sv
`include "mmc_params.svh"

module mmc_host_tb import mmc_pkg::*; ();

  logic          clk;
  logic          arst_n;
  logic          req_valid;
  mmc_req_t      req;
  logic          busy;
  logic          done;
  logic          rd_valid;
  mmc_byte_t     rd_byte;
  mmc_pins_out_t pins_out;
  mmc_pins_in_t  pins_in;
  logic          card_clr;
  mmc_byte_t     card_byte;
  mmc_byte_t     cap_byte;
  logic [3:0]    cap_bits;
  logic [3:0]    rise_cnt;
  logic          started;
  logic          pending;
  logic          rd_seen;
  mmc_byte_t     last_rd;
  logic [31:0]   lcg_state;
  logic          rd_txn;
  logic          wr_txn;
  logic [5:0]    idle_flags;

  mmc_host i_mmc_host (
    .clk         (clk),
    .arst_n_i    (arst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .busy_o      (busy),
    .done_o      (done),
    .rd_valid_o  (rd_valid),
    .rd_byte_o   (rd_byte),
    .pins_o      (pins_out),
    .pins_i      (pins_in)
  );

  mmc_card_model i_mmc_card_model (
    .clr_i      (card_clr),
    .mode_i     (req.mode),
    .width_i    (req.width),
    .tx_byte_i  (card_byte),
    .pins_i     (pins_out),
    .pins_o     (pins_in),
    .cap_byte_o (cap_byte),
    .cap_bits_o (cap_bits),
    .rise_cnt_o (rise_cnt)
  );

  assign rd_txn     = (req.mode == CMD_RD) || (req.mode == DAT_RD);
  assign wr_txn     = !rd_txn;
  assign idle_flags = {busy, done, rd_valid, pins_out.cmd_oe, |pins_out.dat_oe,
                       pins_out.card_clk};

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Card clock rising edges needed to move one byte.
  function automatic int slot_count(adv_mode_e mode, bus_width_e width);
    if (mode == CMD_RD || mode == CMD_WR) begin
      return 8;
    end
    case (width)
      DW_4:    return 2;
      DW_8:    return 1;
      default: return 8;
    endcase
  endfunction

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("FAIL t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
    $display("sim failed");
    $fatal(1, "value check failed");
  endtask

  task automatic report_error(string msg);
    $display("Error at t=%0t: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "check failed");
  endtask

  // Request bookkeeping for the checks below.
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      started <= 1'b0;
      pending <= 1'b0;
      rd_seen <= 1'b0;
      last_rd <= '0;
    end else begin
      if (req_valid) begin
        started <= 1'b1;
        pending <= 1'b1;
      end else if (done) begin
        pending <= 1'b0;
      end
      if (done && rd_txn) begin
        rd_seen <= 1'b1;
        last_rd <= card_byte;
      end
    end
  end

  a_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !started |-> idle_flags == '0)
    else report_mismatch("busy/done/rd_valid/cmd_oe/dat_oe/card_clk", 0, $sampled(idle_flags));

  a_busy_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
    req_valid |=> busy)
    else report_mismatch("busy_o", 1, $sampled(busy));

  a_busy_ends_with_done: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(busy) |-> done)
    else report_mismatch("done_o", 1, $sampled(done));

  a_one_done: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> pending)
    else report_error("done_o pulsed with no request outstanding");

  a_rd_valid: assert property (@(posedge clk) disable iff (!arst_n)
    rd_txn && done |-> rd_valid)
    else report_mismatch("rd_valid_o", 1, $sampled(rd_valid));

  a_rd_valid_with_done: assert property (@(posedge clk) disable iff (!arst_n)
    rd_valid |-> done)
    else report_error("rd_valid_o pulsed without done_o");

  a_rd_byte: assert property (@(posedge clk) disable iff (!arst_n)
    rd_txn && done |-> rd_byte == card_byte)
    else report_mismatch("rd_byte_o", $sampled(card_byte), $sampled(rd_byte));

  a_no_rd_valid_on_wr: assert property (@(posedge clk) disable iff (!arst_n)
    wr_txn |-> !rd_valid)
    else report_mismatch("rd_valid_o", 0, $sampled(rd_valid));

  a_wr_byte: assert property (@(posedge clk) disable iff (!arst_n)
    wr_txn && done |-> cap_byte == req.wr_byte)
    else report_mismatch("cap_byte", $sampled(req.wr_byte), $sampled(cap_byte));

  a_wr_bits: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> cap_bits == (wr_txn ? 4'd8 : 4'd0))
    else report_mismatch("cap_bits", wr_txn ? 8 : 0, $sampled(cap_bits));

  a_rise_cnt: assert property (@(posedge clk) disable iff (!arst_n)
    done |-> rise_cnt == slot_count(req.mode, req.width))
    else report_mismatch("rise_cnt", slot_count(req.mode, req.width), $sampled(rise_cnt));

  a_rd_byte_held: assert property (@(posedge clk) disable iff (!arst_n)
    rd_seen && !rd_valid |-> rd_byte == last_rd)
    else report_mismatch("rd_byte_o", $sampled(last_rd), $sampled(rd_byte));

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < `MMC_TIMEOUT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (busy) begin
      report_error("busy_o did not fall before the timeout");
    end
  endtask

  task automatic run_xfer(adv_mode_e mode, bus_width_e width);
    lcg_state   = lcg_next(lcg_state);
    req.mode    = mode;
    req.width   = width;
    req.wr_byte = lcg_state[23:16];
    lcg_state   = lcg_next(lcg_state);
    card_byte   = lcg_state[23:16];
    req_valid   = 1'b1;
    card_clr    = 1'b1;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    card_clr  = 1'b0;
    wait_idle();
    @(posedge clk);                                // Done cycle gets checked here.
    #2;
  endtask

  initial begin
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    card_clr  = 1'b1;
    card_byte = '0;
    lcg_state = 32'ha7e6;
    repeat (3) @(posedge clk);
    #2;
    arst_n   = 1'b1;
    card_clr = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    // Reads and writes alternate so a held read byte meets a write.
    for (int pass = 0; pass < 2; pass++) begin
      run_xfer(CMD_RD, DW_1);
      run_xfer(CMD_WR, DW_1);
      run_xfer(DAT_RD, DW_1);
      run_xfer(DAT_WR, DW_1);
      run_xfer(DAT_RD, DW_4);
      run_xfer(DAT_WR, DW_4);
      run_xfer(DAT_RD, DW_8);
      run_xfer(DAT_WR, DW_8);
    end
    $display("sim passed");
    $finish;
  end

endmodule
